// File: design/fft_pkg.sv
// shared constants for the 16-point sliding-window FFT monitor
// widths, point count and the radix-4 twiddle tables

package fft_pkg;

	parameter int FFT_POINTS = 16;
	parameter int RADIX = 4;
	parameter int NUM_BINS = FFT_POINTS / 2;

	parameter int SAMPLE_W = 16;
	// sample width plus log2(16) growth plus one bit of margin
	parameter int ACC_W = 21;

	// twiddles are signed Q2.16, 1.0 is 65536
	parameter int TW_W = 18;
	parameter int TW_FRAC = 16;

	parameter int MAG_W = 8;

	// cos(2*pi*k/16)
	parameter logic signed [TW_W-1:0] TW_COS [FFT_POINTS] = '{
		18'sd65536,
		18'sd60547,
		18'sd46341,
		18'sd25080,
		18'sd0,
		-18'sd25080,
		-18'sd46341,
		-18'sd60547,
		-18'sd65536,
		-18'sd60547,
		-18'sd46341,
		-18'sd25080,
		18'sd0,
		18'sd25080,
		18'sd46341,
		18'sd60547
	};

	// -sin(2*pi*k/16), so that W^k = TW_COS[k] + j*TW_SIN[k]
	parameter logic signed [TW_W-1:0] TW_SIN [FFT_POINTS] = '{
		18'sd0,
		-18'sd25080,
		-18'sd46341,
		-18'sd60547,
		-18'sd65536,
		-18'sd60547,
		-18'sd46341,
		-18'sd25080,
		18'sd0,
		18'sd25080,
		18'sd46341,
		18'sd60547,
		18'sd65536,
		18'sd60547,
		18'sd46341,
		18'sd25080
	};

endpackage

// File: design/sample_window.sv
// sliding window of the last 16 input samples
// newest sample sits at the highest index, entries are sign-extended

module sample_window (
	input  logic                                sample_clk,
	input  logic                                rst_n,
	input  logic signed [fft_pkg::SAMPLE_W-1:0] sample_data,
	output logic signed [fft_pkg::ACC_W-1:0]    win_re [fft_pkg::FFT_POINTS]
);

	import fft_pkg::*;

	logic signed [ACC_W-1:0] sample_ext;

	// signed to signed assignment carries the sign bit up
	assign sample_ext = sample_data;

	always_ff @(posedge sample_clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < FFT_POINTS; i++)
			begin
				win_re[i] <= '0;
			end
		end
		else
		begin
			// oldest sample falls off index 0
			for (int i = 0; i < FFT_POINTS - 1; i++)
			begin
				win_re[i] <= win_re[i+1];
			end
			win_re[FFT_POINTS-1] <= sample_ext;
		end
	end

	// the top entry always holds the sample accepted on the last edge
	a_newest_sample: assert property (
		@(posedge sample_clk) rst_n |=> win_re[FFT_POINTS-1] == $past(sample_ext)
	);

endmodule

// File: design/radix4_butterfly.sv
// radix-4 butterfly, combinational four-point DFT
// output q is rotated by the twiddle at index (TW_STEP * q) mod 16
// products are truncated by TW_FRAC bits, index 0 skips the multiplier

module radix4_butterfly #(
	parameter int TW_STEP = 0
) (
	input  logic signed [fft_pkg::ACC_W-1:0] in_re  [fft_pkg::RADIX],
	input  logic signed [fft_pkg::ACC_W-1:0] in_im  [fft_pkg::RADIX],
	output logic signed [fft_pkg::ACC_W-1:0] out_re [fft_pkg::RADIX],
	output logic signed [fft_pkg::ACC_W-1:0] out_im [fft_pkg::RADIX]
);

	import fft_pkg::*;

	logic signed [ACC_W-1:0] dft_re [RADIX];
	logic signed [ACC_W-1:0] dft_im [RADIX];

	// X0 = x0 + x1 + x2 + x3
	// X1 = x0 - j*x1 - x2 + j*x3
	// X2 = x0 - x1 + x2 - x3
	// X3 = x0 + j*x1 - x2 - j*x3
	always_comb
	begin
		dft_re[0] = in_re[0] + in_re[1] + in_re[2] + in_re[3];
		dft_im[0] = in_im[0] + in_im[1] + in_im[2] + in_im[3];

		// -j*(a + jb) = b - ja
		dft_re[1] = in_re[0] + in_im[1] - in_re[2] - in_im[3];
		dft_im[1] = in_im[0] - in_re[1] - in_im[2] + in_re[3];

		dft_re[2] = in_re[0] - in_re[1] + in_re[2] - in_re[3];
		dft_im[2] = in_im[0] - in_im[1] + in_im[2] - in_im[3];

		dft_re[3] = in_re[0] - in_im[1] - in_re[2] + in_im[3];
		dft_im[3] = in_im[0] + in_re[1] - in_im[2] - in_re[3];
	end

	for (genvar q = 0; q < RADIX; q++)
	begin : g_out
		// wrap into 0..15 so negative steps also work
		localparam int TW_IDX = ((TW_STEP * q) % FFT_POINTS + FFT_POINTS) % FFT_POINTS;

		if (TW_IDX == 0)
		begin : g_bypass
			assign out_re[q] = dft_re[q];
			assign out_im[q] = dft_im[q];
		end
		else
		begin : g_rotate
			localparam logic signed [TW_W-1:0] TW_C = TW_COS[TW_IDX];
			localparam logic signed [TW_W-1:0] TW_S = TW_SIN[TW_IDX];

			// one extra bit for the sum of two products
			logic signed [ACC_W+TW_W:0] prod_re;
			logic signed [ACC_W+TW_W:0] prod_im;

			// (a + jb)(c + js) = (ac - bs) + j(as + bc)
			assign prod_re = dft_re[q] * TW_C - dft_im[q] * TW_S;
			assign prod_im = dft_re[q] * TW_S + dft_im[q] * TW_C;

			// drop the fraction, exact for factors 1, -1, j and -j
			assign out_re[q] = prod_re[TW_FRAC +: ACC_W];
			assign out_im[q] = prod_im[TW_FRAC +: ACC_W];
		end
	end

endmodule

// File: design/bin_magnitude.sv
// per-bin magnitude unit
// registers (|re| + |im|) >> MAG_SHIFT, saturated to the 8-bit output range

module bin_magnitude #(
	parameter int MAG_SHIFT = 8
) (
	input  logic                             sample_clk,
	input  logic                             rst_n,
	input  logic signed [fft_pkg::ACC_W-1:0] bin_re,
	input  logic signed [fft_pkg::ACC_W-1:0] bin_im,
	output logic        [fft_pkg::MAG_W-1:0] mag
);

	import fft_pkg::*;

	localparam logic [ACC_W:0] MAG_MAX = (ACC_W + 1)'((1 << MAG_W) - 1);

	logic [ACC_W-1:0] abs_re;
	logic [ACC_W-1:0] abs_im;
	logic [ACC_W:0]   l1_sum;
	logic [ACC_W:0]   l1_shifted;
	logic [MAG_W-1:0] mag_next;

	// unsigned result, so the most negative input still comes out right
	assign abs_re = bin_re[ACC_W-1] ? ACC_W'(-bin_re) : ACC_W'(bin_re);
	assign abs_im = bin_im[ACC_W-1] ? ACC_W'(-bin_im) : ACC_W'(bin_im);

	assign l1_sum = abs_re + abs_im;
	assign l1_shifted = l1_sum >> MAG_SHIFT;

	always_comb
	begin
		if (l1_shifted > MAG_MAX)
		begin
			mag_next = '1;
		end
		else
		begin
			mag_next = l1_shifted[MAG_W-1:0];
		end
	end

	always_ff @(posedge sample_clk)
	begin
		if (!rst_n)
		begin
			mag <= '0;
		end
		else
		begin
			mag <= mag_next;
		end
	end

	// output is cleared on the edge that sees reset
	a_mag_reset: assert property (
		@(posedge sample_clk) !rst_n |=> mag == '0
	);

endmodule

// File: design/fft16_top.sv
// 16-point sliding-window FFT spectrum monitor
// sample window, two ranks of radix-4 butterflies, digit-reversal reorder
// and one registered magnitude unit per output bin

module fft16_top #(
	parameter int MAG_SHIFT = 8
) (
	input  logic                                sample_clk,
	input  logic                                rst_n,
	input  logic signed [fft_pkg::SAMPLE_W-1:0] sample_data,
	output logic        [fft_pkg::MAG_W-1:0]    bin_mag [fft_pkg::NUM_BINS]
);

	import fft_pkg::*;

	logic signed [ACC_W-1:0] win_re [FFT_POINTS];
	logic signed [ACC_W-1:0] s1_re  [FFT_POINTS];
	logic signed [ACC_W-1:0] s1_im  [FFT_POINTS];
	logic signed [ACC_W-1:0] s2_re  [FFT_POINTS];
	logic signed [ACC_W-1:0] s2_im  [FFT_POINTS];

	sample_window u_window (
		.sample_clk  (sample_clk),
		.rst_n       (rst_n),
		.sample_data (sample_data),
		.win_re      (win_re)
	);

	// stage 1, butterfly n takes window taps n, n+4, n+8, n+12
	// and rotates its output q by W^(n*q)
	for (genvar n = 0; n < RADIX; n++)
	begin : g_stage1
		logic signed [ACC_W-1:0] in_re  [RADIX];
		logic signed [ACC_W-1:0] in_im  [RADIX];
		logic signed [ACC_W-1:0] out_re [RADIX];
		logic signed [ACC_W-1:0] out_im [RADIX];

		for (genvar q = 0; q < RADIX; q++)
		begin : g_tap
			assign in_re[q] = win_re[n + RADIX*q];
			// real input signal
			assign in_im[q] = '0;
			assign s1_re[n + RADIX*q] = out_re[q];
			assign s1_im[n + RADIX*q] = out_im[q];
		end

		radix4_butterfly #(
			.TW_STEP (n)
		) u_bf (
			.in_re  (in_re),
			.in_im  (in_im),
			.out_re (out_re),
			.out_im (out_im)
		);
	end

	// stage 2, no twiddles, output 4m+p holds frequency m+4p
	for (genvar m = 0; m < RADIX; m++)
	begin : g_stage2
		logic signed [ACC_W-1:0] in_re  [RADIX];
		logic signed [ACC_W-1:0] in_im  [RADIX];
		logic signed [ACC_W-1:0] out_re [RADIX];
		logic signed [ACC_W-1:0] out_im [RADIX];

		for (genvar p = 0; p < RADIX; p++)
		begin : g_tap
			assign in_re[p] = s1_re[RADIX*m + p];
			assign in_im[p] = s1_im[RADIX*m + p];
			assign s2_re[RADIX*m + p] = out_re[p];
			assign s2_im[RADIX*m + p] = out_im[p];
		end

		radix4_butterfly #(
			.TW_STEP (0)
		) u_bf (
			.in_re  (in_re),
			.in_im  (in_im),
			.out_re (out_re),
			.out_im (out_im)
		);
	end

	// digit-reversal reorder, bin k = m + 4p comes from position 4m + p
	// only the lower half of the spectrum is kept
	for (genvar k = 0; k < NUM_BINS; k++)
	begin : g_bin
		localparam int POS = RADIX * (k % RADIX) + k / RADIX;

		bin_magnitude #(
			.MAG_SHIFT (MAG_SHIFT)
		) u_mag (
			.sample_clk (sample_clk),
			.rst_n      (rst_n),
			.bin_re     (s2_re[POS]),
			.bin_im     (s2_im[POS]),
			.mag        (bin_mag[k])
		);
	end

endmodule

// File: verification/tb_clock_gen.sv
// testbench clock and reset source
// 10 unit clock period, rst_n held low for the first 3 rising edges

module tb_clock_gen #(
	parameter int HALF_PERIOD = 5,
	parameter int RESET_CYCLES = 3
) (
	output logic sample_clk,
	output logic rst_n
);

	initial
	begin
		sample_clk = 1'b0;
		forever
		begin
			#HALF_PERIOD sample_clk = ~sample_clk;
		end
	end

	// release lines up with a rising edge like the rest of the stimulus
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge sample_clk);
		rst_n <= 1'b1;
	end

endmodule

// File: verification/fft16_tb.sv
// testbench for the 16-point sliding-window FFT monitor
// directed tests for reset, zero, DC, quarter-rate tone, saturation and sliding
// expected magnitudes come from the closed-form spectrum of each test signal

module fft16_tb;

	import fft_pkg::*;

	localparam int MAG_SHIFT = 8;
	localparam int CYCLE_LIMIT = 400;
	localparam int MAG_MAX = (1 << MAG_W) - 1;
	localparam int HALF_POINTS = FFT_POINTS / 2;
	localparam real PI = 3.14159265358979;

	logic                       sample_clk;
	logic                       rst_n;
	logic signed [SAMPLE_W-1:0] sample_data;
	logic        [MAG_W-1:0]    bin_mag [NUM_BINS];

	int exp_mag [NUM_BINS];
	int mag_tol [NUM_BINS];
	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;
	int dc_amp;
	int tone_amp;

	tb_clock_gen u_clk (
		.sample_clk (sample_clk),
		.rst_n      (rst_n)
	);

	fft16_top #(
		.MAG_SHIFT (MAG_SHIFT)
	) dut (
		.sample_clk  (sample_clk),
		.rst_n       (rst_n),
		.sample_data (sample_data),
		.bin_mag     (bin_mag)
	);

	// (|re| + |im|) >> MAG_SHIFT, clipped to the 8-bit range
	function automatic int mag_rule(input int l1_sum);
		int shifted;
		shifted = l1_sum >> MAG_SHIFT;
		if (shifted > MAG_MAX)
		begin
			return MAG_MAX;
		end
		return shifted;
	endfunction

	function automatic int abs_int(input int value);
		if (value < 0)
		begin
			return -value;
		end
		return value;
	endfunction

	// odd bins of a window that holds A in its older half and zeros in its newer half
	// X[k] = A * (1 - j*cot(pi*k/16)) and |re| + |im| = |A| * (1 + cot(pi*k/16))
	function automatic int half_window_l1(input int amp, input int k);
		real angle;
		angle = PI * k / FFT_POINTS;
		return $rtoi(abs_int(amp) * (1.0 + $cos(angle) / $sin(angle)));
	endfunction

	// one period of the quarter-rate tone A, 0, -A, 0
	function automatic int quarter_tone_value(input int amp, input int idx);
		int value;
		case (idx % 4)
			0: value = amp;
			2: value = -amp;
			default: value = 0;
		endcase
		return value;
	endfunction

	task automatic clear_expected();
		for (int k = 0; k < NUM_BINS; k++)
		begin
			exp_mag[k] = 0;
			mag_tol[k] = 0;
		end
	endtask

	task automatic shift_in(input int value);
		@(posedge sample_clk);
		sample_data <= SAMPLE_W'(value);
	endtask

	// one edge to accept the last sample, one for the magnitude registers,
	// then sample the outputs half a cycle later
	task automatic settle();
		@(posedge sample_clk);
		@(posedge sample_clk);
		@(negedge sample_clk);
	endtask

	task automatic check_bins(input string test_name);
		for (int k = 0; k < NUM_BINS; k++)
		begin
			check_count++;
			if ($isunknown(bin_mag[k]) || abs_int(int'(bin_mag[k]) - exp_mag[k]) > mag_tol[k])
			begin
				error_count++;
				$display("Fail time=%0t test=%s bin_mag[%0d] expected=%0d actual=%0d",
					$time, test_name, k, exp_mag[k], bin_mag[k]);
			end
		end
	endtask

	// outputs must read 0 straight after reset and one cycle on
	task automatic test_reset();
		wait (rst_n === 1'b1);
		@(negedge sample_clk);
		clear_expected();
		check_bins("reset");
		@(negedge sample_clk);
		check_bins("reset_first_edge");
	endtask

	task automatic test_zero(input string test_name);
		for (int i = 0; i < FFT_POINTS; i++)
		begin
			shift_in(0);
		end
		settle();
		clear_expected();
		check_bins(test_name);
	endtask

	// DC of amplitude A puts 16*A into bin 0 only
	task automatic test_dc(input int amp, input string test_name);
		for (int i = 0; i < FFT_POINTS; i++)
		begin
			shift_in(amp);
		end
		settle();
		clear_expected();
		exp_mag[0] = mag_rule(FFT_POINTS * abs_int(amp));
		check_bins(test_name);
	endtask

	// bin 4 gets 8*A, real for even phases and imaginary for odd ones
	task automatic test_quarter_tone(input int amp, input int phase, input string test_name);
		for (int i = 0; i < FFT_POINTS; i++)
		begin
			shift_in(quarter_tone_value(amp, i + phase));
		end
		settle();
		clear_expected();
		exp_mag[4] = mag_rule(HALF_POINTS * abs_int(amp));
		check_bins(test_name);
	endtask

	// follows a DC run of the same amplitude, window ends half DC, half zero
	task automatic test_slide(input int amp, input string test_name);
		for (int i = 0; i < HALF_POINTS; i++)
		begin
			shift_in(0);
		end
		settle();
		clear_expected();
		exp_mag[0] = mag_rule(HALF_POINTS * abs_int(amp));
		// odd bins go through the rotated stage 1 outputs and carry truncation error
		for (int k = 1; k < NUM_BINS; k += 2)
		begin
			exp_mag[k] = mag_rule(half_window_l1(amp, k));
			mag_tol[k] = 1;
		end
		check_bins(test_name);
	endtask

	task automatic finish_run();
		$display("run complete: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
		begin
			$display("*** TEST PASSED ***");
		end
		else
		begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	always @(posedge sample_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT)
		begin
			$display("Timeout: the tests did not finish within %0d clock cycles",
				CYCLE_LIMIT);
			error_count++;
			finish_run();
		end
	end

	initial
	begin
		sample_data = '0;
		void'($urandom(32'h807f_a439));
		dc_amp = $urandom_range(2047, 1);
		tone_amp = $urandom_range(2047, 1);
		$display("amplitudes: dc=%0d tone=%0d", dc_amp, tone_amp);

		test_reset();
		test_zero("zero");

		test_dc(dc_amp, "dc");
		test_slide(dc_amp, "slide");
		test_dc(-dc_amp, "dc_negative");
		test_slide(-dc_amp, "slide_negative");

		test_quarter_tone(tone_amp, 0, "tone_phase0");
		test_quarter_tone(tone_amp, 1, "tone_phase1");
		test_quarter_tone(tone_amp, 2, "tone_phase2");
		test_quarter_tone(tone_amp, 3, "tone_phase3");

		test_dc(32767, "saturation");
		test_dc(-32768, "saturation_negative");
		test_zero("zero_after_full_scale");

		finish_run();
	end

endmodule

// File: sim.f
design/fft_pkg.sv
design/sample_window.sv
design/radix4_butterfly.sv
design/bin_magnitude.sv
design/fft16_top.sv
verification/tb_clock_gen.sv
verification/fft16_tb.sv
